// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_fetch_top
FILELIST  = sources.f
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== design/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
	input  logic              clk,
	input  logic              rst,

	// fetch side
	input  icache_pkg::addr_t addr,
	input  logic              valid,
	input  logic              flush,
	input  logic              ready_id,
	output icache_pkg::inst_t inst,
	output logic              ready,

	// loader side
	input  logic              load_we,
	input  icache_pkg::addr_t load_addr,
	input  icache_pkg::inst_t load_data
);
	import icache_pkg::*;

	mem_line_addr_t mem_line_addr;
	line_t          mem_line;

	// ----------------------------------------------------------
	// instruction cache
	// ----------------------------------------------------------
	icache u_icache (
		.clk           (clk),
		.rst           (rst),
		.addr          (addr),
		.valid         (valid),
		.flush         (flush),
		.ready_id      (ready_id),
		.mem_line_addr (mem_line_addr),
		.mem_line      (mem_line),
		.inst          (inst),
		.ready         (ready)
	);

	// ----------------------------------------------------------
	// backing program memory
	// ----------------------------------------------------------
	program_mem u_program_mem (
		.clk       (clk),
		.line_addr (mem_line_addr),
		.line      (mem_line),
		.we        (load_we),
		.waddr     (load_addr),
		.wdata     (load_data)
	);

endmodule

// ==== design/icache.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache (
	input  logic                       clk,
	input  logic                       rst,
	input  icache_pkg::addr_t          addr,
	input  logic                       valid,
	input  logic                       flush,
	input  logic                       ready_id,
	output icache_pkg::mem_line_addr_t mem_line_addr,
	input  icache_pkg::line_t          mem_line,
	output icache_pkg::inst_t          inst,
	output logic                       ready
);
	import icache_pkg::*;

	tag_t      tag;
	set_idx_t  index;
	word_sel_t word;
	way_mask_t way_hit;
	way_mask_t rot;                  // replacement rotator
	way_mask_t cen;
	way_mask_t hit_q;
	logic      lookup;
	logic      miss;
	line_t     way_dout [`ICACHE_WAYS];
	line_t     line_q;               // miss line copy
	word_sel_t word_q;
	line_t     resp_line;

	// ----------------------------------------------------------
	// address split and enables
	// ----------------------------------------------------------
	assign tag           = addr[63:`ICACHE_OFFSET_BITS+`ICACHE_INDEX_BITS];
	assign index         = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
	assign word          = addr[`ICACHE_OFFSET_BITS-1:2];
	assign mem_line_addr = addr[`ICACHE_OFFSET_BITS +: `MEM_LINE_BITS];

	assign lookup = valid && ready_id;
	assign miss   = lookup && (way_hit == '0);

	icache_tag_store u_tag_store (
		.clk      (clk),
		.rst      (rst),
		.en       (ready_id),
		.index    (index),
		.tag      (tag),
		.valid    (valid),
		.fill_way (rot),
		.way_hit  (way_hit)
	);

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		assign cen[w] = (lookup && way_hit[w]) || (miss && rot[w]);

		icache_sram u_sram (
			.clk   (clk),
			.cen   (cen[w]),
			.wen   (miss),
			.index (index),
			.din   (mem_line),
			.dout  (way_dout[w])
		);
	end

	// ----------------------------------------------------------
	// response registers
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q <= '0;
			rot   <= way_mask_t'(1);     // way 0 first
			ready <= 1'b0;
		end else if (ready_id) begin
			if (flush) begin
				hit_q <= '0;
				ready <= 1'b0;
			end else begin
				hit_q <= valid ? way_hit : '0;
				rot   <= {rot[`ICACHE_WAYS-2:0], rot[`ICACHE_WAYS-1]};
				ready <= valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ready_id && !flush) begin
			line_q <= mem_line;
			word_q <= word;
		end
	end

	// hitting way or miss copy, then the word
	always_comb begin
		resp_line = line_q;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit_q[w]) begin
				resp_line = way_dout[w];
			end
		end
	end

	assign inst = resp_line[`ICACHE_WORD_BITS*word_q +: `ICACHE_WORD_BITS];

	a_rot_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot(rot)
	) else $error("icache: rotator not one-hot");

	a_flush_drops_ready: assert property (
		@(posedge clk) disable iff (rst)
		ready_id && flush |=> !ready
	) else $error("icache: ready after flush");

endmodule

// ==== design/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ----------------------------------------------------------
// cache geometry
// ----------------------------------------------------------
`define ICACHE_WAYS        4
`define ICACHE_SETS        64
`define ICACHE_LINE_BYTES  16
`define ICACHE_OFFSET_BITS 4    // byte offset within a line
`define ICACHE_INDEX_BITS  6    // set index, addr[9:4]
`define ICACHE_WORD_BITS   32   // one instruction

// ----------------------------------------------------------
// backing memory
// ----------------------------------------------------------
`define MEM_LINE_BITS      10   // 1024 lines, upper bits wrap

`endif

// ==== design/icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

	// byte address and fetched word
	typedef logic [63:0]                          addr_t;
	typedef logic [`ICACHE_WORD_BITS-1:0]         inst_t;

	// one full cache line
	typedef logic [`ICACHE_LINE_BYTES*8-1:0]      line_t;

	// address fields
	typedef logic [63-`ICACHE_OFFSET_BITS-`ICACHE_INDEX_BITS:0] tag_t;   // addr[63:10]
	typedef logic [`ICACHE_INDEX_BITS-1:0]        set_idx_t;              // addr[9:4]
	typedef logic [`ICACHE_OFFSET_BITS-3:0]       word_sel_t;             // addr[3:2]

	// hit mask and replacement choice
	typedef logic [`ICACHE_WAYS-1:0]              way_mask_t;

	// program memory line address
	typedef logic [`MEM_LINE_BITS-1:0]            mem_line_addr_t;

endpackage

// ==== design/icache_sram.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_sram (
	input  logic                 clk,
	input  logic                 cen,
	input  logic                 wen,
	input  icache_pkg::set_idx_t index,
	input  icache_pkg::line_t    din,
	output icache_pkg::line_t    dout
);
	import icache_pkg::*;

	line_t mem [`ICACHE_SETS];

	// single port, registered output
	always_ff @(posedge clk) begin
		if (cen) begin
			if (wen) begin
				mem[index] <= din;
				dout       <= din;         // write-through read
			end else begin
				dout <= mem[index];
			end
		end
	end

endmodule

// ==== design/icache_tag_store.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_tag_store (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en,
	input  icache_pkg::set_idx_t  index,
	input  icache_pkg::tag_t      tag,
	input  logic                  valid,
	input  icache_pkg::way_mask_t fill_way,
	output icache_pkg::way_mask_t way_hit
);
	import icache_pkg::*;

	tag_t                   tags [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] vld [`ICACHE_WAYS];
	logic                   fill;

	// ----------------------------------------------------------
	// lookup
	// ----------------------------------------------------------
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_hit[w] = vld[w][index] && (tags[w][index] == tag);
		end
	end

	assign fill = en && valid && (way_hit == '0);   // miss

	// ----------------------------------------------------------
	// fill on miss
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				vld[w] <= '0;
			end
		end else if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (fill_way[w]) begin
					vld[w][index] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][index] <= tag;
				end
			end
		end
	end

	// a line never sits in two ways of a set
	a_hit_onehot0: assert property (
		@(posedge clk) disable iff (rst)
		en && valid |-> $onehot0(way_hit)
	) else $error("tag store: more than one way hit");

	// replacement choice comes from the cache rotator
	a_fill_onehot: assert property (
		@(posedge clk) disable iff (rst)
		fill |-> $onehot(fill_way)
	) else $error("tag store: fill way not one-hot");

endmodule

// ==== design/program_mem.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module program_mem (
	input  logic                       clk,
	input  icache_pkg::mem_line_addr_t line_addr,
	output icache_pkg::line_t          line,
	input  logic                       we,
	input  icache_pkg::addr_t          waddr,
	input  icache_pkg::inst_t          wdata
);
	import icache_pkg::*;

	line_t          mem [2**`MEM_LINE_BITS];
	mem_line_addr_t wline;
	word_sel_t      wword;

	// ----------------------------------------------------------
	// loader side, one word per clock
	// ----------------------------------------------------------
	assign wline = waddr[`ICACHE_OFFSET_BITS +: `MEM_LINE_BITS];   // wraps
	assign wword = waddr[`ICACHE_OFFSET_BITS-1:2];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wline][`ICACHE_WORD_BITS*wword +: `ICACHE_WORD_BITS] <= wdata;
		end
	end

	// ----------------------------------------------------------
	// fetch side, whole line
	// ----------------------------------------------------------
	assign line = mem[line_addr];   // combinational read

endmodule

// ==== sources.f ====
+incdir+design
design/icache_pkg.sv
design/icache_sram.sv
design/icache_tag_store.sv
design/icache.sv
design/program_mem.sv
design/fetch_top.sv
tests/tb_fetch_top.sv

// ==== tests/tb_fetch_top.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module tb_fetch_top;
	import icache_pkg::*;

	localparam int RESET_CYCLES    = 5;
	localparam int MODEL_WORDS     = 2**(`MEM_LINE_BITS+2);   // whole program memory
	localparam int RAND_FETCHES    = 400;
	localparam int DIRECTED_CYCLES = 200;                     // tests 1 to 5
	localparam int MAX_CYCLES      =
		2*(RESET_CYCLES + MODEL_WORDS + DIRECTED_CYCLES + 10*RAND_FETCHES);

	logic   clk;
	logic   rst;
	addr_t  addr;
	logic   valid;
	logic   flush;
	logic   ready_id;
	inst_t  inst;
	logic   ready;
	logic   load_we;
	addr_t  load_addr;
	inst_t  load_data;

	inst_t  model [MODEL_WORDS];      // mirror of every loader write
	integer seed = 49045;
	int     cycle_count = 0;

	fetch_top DUT (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.valid     (valid),
		.flush     (flush),
		.ready_id  (ready_id),
		.inst      (inst),
		.ready     (ready),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_data (load_data)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$fatal(1, "simulation timed out");
		end
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	function automatic inst_t expected_word(addr_t a);
		return model[a[`MEM_LINE_BITS+3:2]];   // line bits wrap
	endfunction

	task automatic fail_run();
		$display("Finished with errors");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_response(string name, inst_t exp);
		assert (ready === 1'b1) else begin
			$display("Error: test %s, ready expected 1 actual %b", name, ready);
			fail_run();
		end
		assert (inst === exp) else begin
			$display("Error: test %s, inst expected %h actual %h", name, exp, inst);
			fail_run();
		end
	endtask

	task automatic check_idle(string name);
		assert (ready === 1'b0) else begin
			$display("Error: test %s, ready expected 0 actual %b", name, ready);
			fail_run();
		end
	endtask

	task automatic load_program();
		inst_t w;
		for (int i = 0; i < MODEL_WORDS; i++) begin
			w = $random(seed);
			@(posedge clk);
			load_we   <= 1'b1;
			load_addr <= addr_t'(i * 4);
			load_data <= w;
			model[i] = w;
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	// one request, then optionally hold the decode stage
	task automatic fetch_word(string name, addr_t a, int stall);
		inst_t exp;
		exp = expected_word(a);
		@(posedge clk);
		addr     <= a;
		valid    <= 1'b1;
		ready_id <= 1'b1;
		flush    <= 1'b0;
		@(posedge clk);
		valid    <= 1'b0;
		ready_id <= (stall == 0);
		@(negedge clk);
		check_response(name, exp);
		repeat (stall) begin
			@(posedge clk);
			@(negedge clk);
			check_response(name, exp);   // outputs must hold
		end
	endtask

	task automatic flush_request(string name, addr_t a);
		@(posedge clk);
		addr     <= a;
		valid    <= 1'b1;
		ready_id <= 1'b1;
		flush    <= 1'b1;
		@(posedge clk);
		valid <= 1'b0;
		flush <= 1'b0;
		@(negedge clk);
		check_idle(name);
	endtask

	// ----------------------------------------------------------
	// tests
	// ----------------------------------------------------------
	addr_t cold_addrs [6];

	task automatic test_cold_misses();
		@(negedge clk);
		check_idle("reset");
		foreach (cold_addrs[i]) begin
			fetch_word("cold_misses", cold_addrs[i], 0);
		end
	endtask

	task automatic test_hits();
		foreach (cold_addrs[i]) begin
			fetch_word("hits", cold_addrs[i], 0);
		end
		for (int k = 0; k < 4; k++) begin
			fetch_word("hits", 64'h120 + addr_t'(k * 4), 0);   // every word of one line
		end
	endtask

	task automatic test_set_eviction();
		addr_t a;
		for (int pass = 0; pass < 2; pass++) begin
			for (int k = 0; k < 8; k++) begin
				a = 64'h50 + addr_t'(k * 32'h400) + addr_t'((k % 4) * 4);   // set 5
				fetch_word("set_eviction", a, 0);
			end
		end
	endtask

	task automatic test_stall_hold();
		fetch_word("stall_hold", 64'h600, 6);
		fetch_word("stall_hold", 64'h2608, 0);
	endtask

	task automatic test_flush();
		flush_request("flush", 64'h3a4);   // miss, fill still happens
		fetch_word("flush", 64'h3a4, 0);
		flush_request("flush", 64'h14);    // hit
		fetch_word("flush", 64'h14, 0);
	endtask

	task automatic test_random_fetch();
		int    r;
		int    r2;
		int    stall;
		addr_t a;
		for (int n = 0; n < RAND_FETCHES; n++) begin
			r  = $random(seed);
			r2 = $random(seed);
			a  = 64'h1000 + addr_t'(r & 32'h7fc);   // 2 KiB region
			stall = (r2[1:0] == 2'b00) ? int'(r2[4:2]) + 1 : 0;
			fetch_word("random_fetch", a, stall);
		end
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		clk = 1'b0;
		rst       <= 1'b1;
		addr      <= '0;
		valid     <= 1'b0;
		flush     <= 1'b0;
		ready_id  <= 1'b0;
		load_we   <= 1'b0;
		load_addr <= '0;
		load_data <= '0;
		cold_addrs = '{64'h0, 64'h14, 64'h128, 64'h3f0, 64'h1_0000_0040, 64'h2a0c};
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		load_program();
		test_cold_misses();
		test_hits();
		test_set_eviction();
		test_stall_hold();
		test_flush();
		test_random_fetch();

		$display("Finished with no errors");
		$finish;
	end

endmodule
